// ==== source/channel_sum_pkg.sv ====
package channel_sum_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes

  localparam int CHANNELS    = 8;
  localparam int MAP_PIXELS  = 16;
  localparam int PIXEL_WIDTH = 16;
  localparam int TREE_LEVELS = $clog2(CHANNELS);

  // Each tree level adds one bit, so the full sum cannot overflow
  localparam int SUM_WIDTH = PIXEL_WIDTH + TREE_LEVELS;

  localparam int PIXEL_COUNT_WIDTH   = $clog2(MAP_PIXELS);
  localparam int CHANNEL_COUNT_WIDTH = $clog2(CHANNELS);

  //////////////////////////////////////////////////////////////////////
  // Types

  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
  typedef logic signed [SUM_WIDTH-1:0]   sum_t;

  // Index k holds channel CHANNELS-1-k of one pixel position
  typedef pixel_t [CHANNELS-1:0] tap_vector_t;

  typedef struct packed {
    logic last_channel;
    logic last_pixel;
  } frame_pos_t;

  typedef struct packed {
    sum_t sum;
    logic frame_end;
  } sum_beat_t;

endpackage

// ==== source/pixel_delay_line.sv ====
`timescale 1ns/1ps

module pixel_delay_line
  import channel_sum_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   shift,
  input  pixel_t pixel_in,
  output pixel_t pixel_out
);

  // Entry 0 holds the newest accepted pixel
  pixel_t entries [MAP_PIXELS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MAP_PIXELS; i++) begin
        entries[i] <= '0;
      end
    end else if (shift) begin
      entries[0] <= pixel_in;
      for (int i = 1; i < MAP_PIXELS; i++) begin
        entries[i] <= entries[i-1];
      end
    end
  end

  // Oldest entry is the same position one map earlier
  assign pixel_out = entries[MAP_PIXELS-1];

  // A cleared line must never feed unknowns into the tree
  output_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(pixel_out)
  ) else $error("delay line output is unknown");

endmodule

// ==== source/sum_node.sv ====
`timescale 1ns/1ps

module sum_node #(
  parameter type operand_t = logic signed [7:0],
  parameter type result_t  = logic signed [8:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     valid_in,
  input  operand_t a,
  input  operand_t b,
  output result_t  result,
  output logic     valid_out
);

  result_t sum_q;

  // Operands are signed, so the casts sign-extend before the add
  always_ff @(posedge clk) begin
    if (valid_in) begin
      sum_q <= result_t'(a) + result_t'(b);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  assign result = sum_q;

  // Held result must stay put between accepted operand pairs
  result_holds: assert property (
    @(posedge clk) disable iff (reset)
    $changed(sum_q) |-> $past(valid_in)
  ) else $error("sum node result changed without a valid input");

endmodule

// ==== source/adder_tree.sv ====
`timescale 1ns/1ps

module adder_tree
  import channel_sum_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  tap_vector_t taps,
  input  logic        taps_valid,
  output sum_t        sum,
  output logic        sum_valid
);

  localparam int NODES_L0 = CHANNELS / 2;
  localparam int NODES_L1 = CHANNELS / 4;

  typedef logic signed [PIXEL_WIDTH:0]   level0_sum_t;
  typedef logic signed [PIXEL_WIDTH+1:0] level1_sum_t;

  level0_sum_t         sum_l0 [NODES_L0];
  logic [NODES_L0-1:0] valid_l0;
  level1_sum_t         sum_l1 [NODES_L1];
  logic [NODES_L1-1:0] valid_l1;

  //////////////////////////////////////////////////////////////////////
  // Level 0, tap i pairs with tap i+CHANNELS/2

  for (genvar i = 0; i < NODES_L0; i++) begin : g_level0
    sum_node #(
      .operand_t(pixel_t),
      .result_t (level0_sum_t)
    ) u_node (
      .clk      (clk),
      .reset    (reset),
      .valid_in (taps_valid),
      .a        (taps[i]),
      .b        (taps[i+NODES_L0]),
      .result   (sum_l0[i]),
      .valid_out(valid_l0[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Level 1

  for (genvar i = 0; i < NODES_L1; i++) begin : g_level1
    sum_node #(
      .operand_t(level0_sum_t),
      .result_t (level1_sum_t)
    ) u_node (
      .clk      (clk),
      .reset    (reset),
      .valid_in (valid_l0[i] & valid_l0[i+NODES_L1]),
      .a        (sum_l0[i]),
      .b        (sum_l0[i+NODES_L1]),
      .result   (sum_l1[i]),
      .valid_out(valid_l1[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Level 2, final sum

  sum_node #(
    .operand_t(level1_sum_t),
    .result_t (sum_t)
  ) u_root (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_l1[0] & valid_l1[1]),
    .a        (sum_l1[0]),
    .b        (sum_l1[1]),
    .result   (sum),
    .valid_out(sum_valid)
  );

  // All nodes of a level see the same beat, so their valids move together
  level_valids_aligned: assert property (
    @(posedge clk) disable iff (reset)
    (&valid_l0 == |valid_l0) && (&valid_l1 == |valid_l1)
  ) else $error("adder tree operand valids are misaligned");

endmodule

// ==== source/frame_position_counter.sv ====
`timescale 1ns/1ps

module frame_position_counter
  import channel_sum_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       pixel_valid,
  output frame_pos_t position
);

  logic [PIXEL_COUNT_WIDTH-1:0]   pixel_count;
  logic [CHANNEL_COUNT_WIDTH-1:0] channel_count;

  // Flags describe the pixel accepted this cycle
  always_comb begin
    position.last_pixel   = (pixel_count == PIXEL_COUNT_WIDTH'(MAP_PIXELS - 1));
    position.last_channel = (channel_count == CHANNEL_COUNT_WIDTH'(CHANNELS - 1));
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_count   <= '0;
      channel_count <= '0;
    end else if (pixel_valid) begin
      if (position.last_pixel) begin
        pixel_count <= '0;
        // Wrap to channel 0 at the end of the frame
        if (position.last_channel) begin
          channel_count <= '0;
        end else begin
          channel_count <= channel_count + 1'b1;
        end
      end else begin
        pixel_count <= pixel_count + 1'b1;
      end
    end
  end

  frame_wraps: assert property (
    @(posedge clk) disable iff (reset)
    pixel_valid && position.last_pixel && position.last_channel
    |=> (pixel_count == '0) && (channel_count == '0)
  ) else $error("frame position did not wrap after the last pixel");

endmodule

// ==== source/channel_adder.sv ====
`timescale 1ns/1ps

module channel_adder
  import channel_sum_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  pixel_t    pixel_in,
  input  logic      pixel_valid,
  output sum_beat_t sum_out,
  output logic      sum_valid
);

  pixel_t                 chain [CHANNELS];
  frame_pos_t             position;
  tap_vector_t            taps;
  logic                   taps_valid;
  logic                   tap_last_pixel;
  logic [TREE_LEVELS-1:0] frame_end_pipe;
  sum_t                   tree_sum;

  //////////////////////////////////////////////////////////////////////
  // Delay chain, one map per link

  assign chain[0] = pixel_in;

  for (genvar k = 0; k < CHANNELS - 1; k++) begin : g_delay
    pixel_delay_line u_line (
      .clk      (clk),
      .reset    (reset),
      .shift    (pixel_valid),
      .pixel_in (chain[k]),
      .pixel_out(chain[k+1])
    );
  end

  frame_position_counter u_counter (
    .clk        (clk),
    .reset      (reset),
    .pixel_valid(pixel_valid),
    .position   (position)
  );

  //////////////////////////////////////////////////////////////////////
  // Tap capture

  // Chain link k holds channel CHANNELS-1-k on a last-channel beat
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      for (int k = 0; k < CHANNELS; k++) begin
        taps[k] <= chain[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      taps_valid     <= 1'b0;
      tap_last_pixel <= 1'b0;
      frame_end_pipe <= '0;
    end else begin
      taps_valid <= pixel_valid && position.last_channel;
      if (pixel_valid) begin
        tap_last_pixel <= position.last_pixel;
      end
      // Matches the fixed depth of the tree
      frame_end_pipe <= {frame_end_pipe[TREE_LEVELS-2:0], taps_valid && tap_last_pixel};
    end
  end

  adder_tree u_tree (
    .clk       (clk),
    .reset     (reset),
    .taps      (taps),
    .taps_valid(taps_valid),
    .sum       (tree_sum),
    .sum_valid (sum_valid)
  );

  assign sum_out = '{sum: tree_sum, frame_end: frame_end_pipe[TREE_LEVELS-1]};

  // The side pipe and the tree must stay in step
  frame_end_on_sum: assert property (
    @(posedge clk) disable iff (reset)
    sum_out.frame_end |-> sum_valid
  ) else $error("frame end flag without a summed pixel");

endmodule

// ==== verification/channel_adder_tb.sv ====
`timescale 1ns/1ps

module channel_adder_tb
  import channel_sum_pkg::*;
();

  localparam int          CLOCK_PERIOD    = 40;
  localparam int          RESET_CYCLES    = 16;
  localparam int          NUM_FRAMES      = 8;
  localparam int          FRAME_BEATS     = CHANNELS * MAP_PIXELS;
  localparam int          WATCHDOG_CYCLES = NUM_FRAMES * FRAME_BEATS * 2 + 100;
  localparam logic [31:0] RANDOM_SEED     = 32'hb531_a280;

  localparam pixel_t PIXEL_MAX = {1'b0, {(PIXEL_WIDTH-1){1'b1}}};
  localparam pixel_t PIXEL_MIN = {1'b1, {(PIXEL_WIDTH-1){1'b0}}};

  logic      clk;
  logic      reset;
  pixel_t    pixel_in;
  logic      pixel_valid;
  sum_beat_t sum_out;
  logic      sum_valid;

  // Channel values of the frame being fed
  pixel_t    frame_pixels [CHANNELS][MAP_PIXELS];
  sum_beat_t expected_q [$];
  int        sums_seen;

  channel_adder DUT (
    .clk        (clk),
    .reset      (reset),
    .pixel_in   (pixel_in),
    .pixel_valid(pixel_valid),
    .sum_out    (sum_out),
    .sum_valid  (sum_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLOCK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference and checks

  function automatic sum_t sum_pixel(input int position);
    sum_t total;
    total = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      total = total + sum_t'(frame_pixels[c][position]);
    end
    return total;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_sum(input sum_t actual, input sum_t expected);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch at %0t ns: sum_out.sum is %0d, expected %0d",
                         $time, actual, expected));
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch at %0t ns: sum_out.frame_end is %b, expected %b",
                         $time, actual, expected));
    end
  endtask

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin : compare_sums
    sum_beat_t expected_beat;
    if (sum_valid === 1'b1) begin
      sums_seen++;
      if (expected_q.size() == 0) begin
        fail_run("sum_valid was raised while no summed pixel was outstanding");
      end else begin
        expected_beat = expected_q.pop_front();
        check_sum(sum_out.sum, expected_beat.sum);
        check_flag(sum_out.frame_end, expected_beat.frame_end);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic idle_cycle();
    @(negedge clk);
    pixel_valid = 1'b0;
    pixel_in    = pixel_t'($urandom);
  endtask

  task automatic fill_random_frame();
    for (int c = 0; c < CHANNELS; c++) begin
      for (int p = 0; p < MAP_PIXELS; p++) begin
        frame_pixels[c][p] = pixel_t'($urandom);
      end
    end
  endtask

  task automatic fill_constant_frame(input pixel_t value);
    for (int c = 0; c < CHANNELS; c++) begin
      for (int p = 0; p < MAP_PIXELS; p++) begin
        frame_pixels[c][p] = value;
      end
    end
  endtask

  // At most one idle cycle per pixel when gaps are on
  task automatic feed_frame(input bit with_gaps);
    sum_beat_t beat;
    for (int c = 0; c < CHANNELS; c++) begin
      for (int p = 0; p < MAP_PIXELS; p++) begin
        if (with_gaps && ($urandom_range(0, 1) == 1)) begin
          idle_cycle();
        end
        @(negedge clk);
        pixel_in    = frame_pixels[c][p];
        pixel_valid = 1'b1;
        if (c == CHANNELS - 1) begin
          beat.sum       = sum_pixel(p);
          beat.frame_end = (p == MAP_PIXELS - 1);
          expected_q.push_back(beat);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(RANDOM_SEED));
    reset       = 1'b1;
    pixel_valid = 1'b0;
    pixel_in    = '0;
    sums_seen   = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Back to back random frames
    repeat (2) begin
      fill_random_frame();
      feed_frame(1'b0);
    end
    repeat (3) idle_cycle();

    repeat (2) begin
      fill_random_frame();
      feed_frame(1'b1);
    end
    repeat (3) idle_cycle();

    // Full scale sums
    repeat (2) begin
      fill_constant_frame(PIXEL_MAX);
      feed_frame(1'b0);
    end
    repeat (2) begin
      fill_constant_frame(PIXEL_MIN);
      feed_frame(1'b0);
    end
    idle_cycle();

    // Let the tree drain and catch stray strobes
    repeat (8) idle_cycle();

    if (expected_q.size() != 0 || sums_seen != NUM_FRAMES * MAP_PIXELS) begin
      fail_run($sformatf("Expected %0d summed pixels but saw %0d, %0d still outstanding",
                         NUM_FRAMES * MAP_PIXELS, sums_seen, expected_q.size()));
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    fail_run("Watchdog expired before all summed pixels were checked");
  end

endmodule

// ==== channel_adder.f ====
source/channel_sum_pkg.sv
source/pixel_delay_line.sv
source/sum_node.sv
source/adder_tree.sv
source/frame_position_counter.sv
source/channel_adder.sv
verification/channel_adder_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = channel_adder_tb
FILELIST  = channel_adder.f
OBJ_DIR   = obj_dir
PASS_TEXT = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@output="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
